/* logic/cache_consts.svh */
// Blocking cache constants
// Address, word and line widths plus address field positions

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Data path widths
`define CACHE_ADDR_W   32
`define CACHE_WORD_W   32
`define CACHE_LINE_W   128

// Geometry: 16 lines of four words
`define CACHE_LINES    16
`define CACHE_IDX_W    4
`define CACHE_TAG_W    24

// Address fields: tag 31:8, index 7:4, word offset 3:2
`define CACHE_OFF_LSB  2
`define CACHE_IDX_LSB  4
`define CACHE_TAG_LSB  8

`endif

/* logic/cache_pkg.sv */
// Blocking cache types
// Request type encoding and the word, line and tag payloads

`include "cache_consts.svh"

package cache_pkg;

  // ------------------------------------------------------------------------
  // Request and response type
  // ------------------------------------------------------------------------

  // Memory side only ever carries REQ_READ and REQ_WRITE
  typedef enum logic [1:0] {
    REQ_READ  = 2'd0,
    REQ_WRITE = 2'd1,
    REQ_INIT  = 2'd2
  } req_type_e;

  // ------------------------------------------------------------------------
  // Payloads
  // ------------------------------------------------------------------------

  typedef logic [`CACHE_WORD_W-1:0] word_t;

  // Word 0 sits in the low bits
  typedef logic [`CACHE_LINE_W-1:0] line_t;

  typedef logic [`CACHE_TAG_W-1:0]  tag_t;

endpackage

/* logic/cache_sram.sv */
// Cache storage array
// One entry per line, registered read and whole-entry write on one address

`timescale 1ns/1ns

`include "cache_consts.svh"

module cache_sram #(
  parameter type entry_t = cache_pkg::line_t
) (
  input  logic                    clk,
  input  logic [`CACHE_IDX_W-1:0] addr,
  input  logic                    wen,
  input  entry_t                  wdata,
  output entry_t                  rdata
);

  entry_t mem [`CACHE_LINES];

  // Write updates the entry, read returns the old contents on a collision
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= wdata;
    end
  end

  // Read data valid one cycle after the address
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* logic/cache_ctrl.sv */
// Blocking cache controller
// FSM for tag check, data access, eviction and refill, plus valid/dirty bits

`timescale 1ns/1ns

`include "cache_consts.svh"

module cache_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cachereq_val,
  output logic                    cachereq_rdy,
  output logic                    cacheresp_val,
  input  logic                    cacheresp_rdy,
  output logic                    memreq_val,
  input  logic                    memreq_rdy,
  input  logic                    memresp_val,
  output logic                    memresp_rdy,
  input  cache_pkg::req_type_e    req_type,
  input  logic [`CACHE_IDX_W-1:0] req_idx,
  input  logic                    tag_match,
  output logic                    req_en,
  output logic                    tag_wen,
  output logic                    data_wen,
  output logic                    line_sel,
  output logic                    memresp_en,
  output logic                    evict_sel,
  output cache_pkg::req_type_e    memreq_type
);

  import cache_pkg::*;

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    DATA_ACCESS,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE,
    RESP
  } state_e;

  state_e state;
  state_e state_next;

  logic [`CACHE_LINES-1:0] valid_bits;
  logic [`CACHE_LINES-1:0] dirty_bits;

  logic hit;
  logic need_evict;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Init always counts as a hit, it claims the line outright
  assign hit        = (req_type == REQ_INIT) || (valid_bits[req_idx] && tag_match);
  assign need_evict = valid_bits[req_idx] && dirty_bits[req_idx];

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE:          if (cachereq_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (hit) begin
          state_next = DATA_ACCESS;
        end else if (need_evict) begin
          state_next = EVICT_REQ;
        end else begin
          state_next = REFILL_REQ;
        end
      end
      DATA_ACCESS:   state_next = RESP;
      EVICT_REQ:     if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:    if (memresp_val) state_next = REFILL_REQ;
      REFILL_REQ:    if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:   if (memresp_val) state_next = REFILL_UPDATE;
      // Refilled line goes through the normal data access next
      REFILL_UPDATE: state_next = DATA_ACCESS;
      RESP:          if (cacheresp_rdy) state_next = IDLE;
      default:       state_next = IDLE;
    endcase
  end

  // --------------------------------------------------------------------------
  // Outputs and datapath strobes
  // --------------------------------------------------------------------------

  assign cachereq_rdy  = (state == IDLE);
  assign req_en        = (state == IDLE) && cachereq_val;
  assign cacheresp_val = (state == RESP);

  assign memreq_val  = (state == EVICT_REQ) || (state == REFILL_REQ);
  assign memreq_type = (state == EVICT_REQ) ? REQ_WRITE : REQ_READ;
  assign evict_sel   = (state == EVICT_REQ);

  // Eviction responses are only acknowledged, never captured
  assign memresp_rdy = (state == EVICT_WAIT) || (state == REFILL_WAIT);
  assign memresp_en  = (state == REFILL_WAIT) && memresp_val;

  // Write merged line on write/init, raw refill line on refill update
  assign data_wen = ((state == DATA_ACCESS) && (req_type != REQ_READ))
                 || (state == REFILL_UPDATE);
  assign tag_wen  = ((state == DATA_ACCESS) && (req_type == REQ_INIT))
                 || (state == REFILL_UPDATE);
  assign line_sel = (state == REFILL_UPDATE);

  // --------------------------------------------------------------------------
  // Valid and dirty bits
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (state == REFILL_UPDATE) begin
      valid_bits[req_idx] <= 1'b1;
      dirty_bits[req_idx] <= 1'b0;
    end else if (state == DATA_ACCESS) begin
      if (req_type == REQ_WRITE) begin
        dirty_bits[req_idx] <= 1'b1;
      end else if (req_type == REQ_INIT) begin
        // Init data matches memory, so the line is clean
        valid_bits[req_idx] <= 1'b1;
        dirty_bits[req_idx] <= 1'b0;
      end
    end
  end

endmodule

/* logic/cache_dpath.sv */
// Blocking cache datapath
// Request registers, tag/data arrays, tag compare, word merge and select

`timescale 1ns/1ns

`include "cache_consts.svh"

module cache_dpath (
  input  logic                     clk,
  input  logic                     req_en,
  input  cache_pkg::req_type_e     cachereq_type,
  input  logic [`CACHE_ADDR_W-1:0] cachereq_addr,
  input  cache_pkg::word_t         cachereq_data,
  input  logic                     tag_wen,
  input  logic                     data_wen,
  input  logic                     line_sel,
  input  logic                     memresp_en,
  input  logic                     evict_sel,
  input  cache_pkg::line_t         memresp_data,
  output cache_pkg::req_type_e     req_type,
  output logic [`CACHE_IDX_W-1:0]  req_idx,
  output logic                     tag_match,
  output cache_pkg::req_type_e     cacheresp_type,
  output cache_pkg::word_t         cacheresp_data,
  output logic [`CACHE_ADDR_W-1:0] memreq_addr,
  output cache_pkg::line_t         memreq_data
);

  import cache_pkg::*;

  localparam int OFF_W = `CACHE_IDX_LSB - `CACHE_OFF_LSB;

  logic [`CACHE_ADDR_W-1:0] req_addr;
  word_t                    req_data;
  line_t                    refill_line;
  logic                     refilled;
  tag_t                     req_tag;
  logic [OFF_W-1:0]         req_off;
  logic [`CACHE_IDX_W-1:0]  array_idx;
  tag_t                     tag_rdata;
  line_t                    data_rdata;
  line_t                    src_line;
  line_t                    merged_line;
  line_t                    write_line;

  // Request payload registers
  always_ff @(posedge clk) begin
    if (req_en) begin
      req_type <= cachereq_type;
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
  end

  // Refill line capture and a flag for requests answered from memory
  always_ff @(posedge clk) begin
    if (memresp_en) begin
      refill_line <= memresp_data;
    end
    if (req_en) begin
      refilled <= 1'b0;
    end else if (memresp_en) begin
      refilled <= 1'b1;
    end
  end

  assign req_tag = req_addr[`CACHE_TAG_LSB +: `CACHE_TAG_W];
  assign req_idx = req_addr[`CACHE_IDX_LSB +: `CACHE_IDX_W];
  assign req_off = req_addr[`CACHE_OFF_LSB +: OFF_W];

  // Arrays look up the incoming index on accept and the stored one after
  assign array_idx = req_en ? cachereq_addr[`CACHE_IDX_LSB +: `CACHE_IDX_W] : req_idx;

  cache_sram #(.entry_t(tag_t)) tag_array (
    .clk   (clk),
    .addr  (array_idx),
    .wen   (tag_wen),
    .wdata (req_tag),
    .rdata (tag_rdata)
  );

  cache_sram #(.entry_t(line_t)) data_array (
    .clk   (clk),
    .addr  (array_idx),
    .wen   (data_wen),
    .wdata (write_line),
    .rdata (data_rdata)
  );

  assign tag_match = (tag_rdata == req_tag);

  // Array read lags a refill write by a cycle, so use the captured line
  assign src_line = refilled ? refill_line : data_rdata;

  always_comb begin
    merged_line = src_line;
    merged_line[req_off * `CACHE_WORD_W +: `CACHE_WORD_W] = req_data;
  end

  assign write_line = line_sel ? refill_line : merged_line;

  // Write and init responses carry no data
  assign cacheresp_data = (req_type == REQ_READ)
                        ? src_line[req_off * `CACHE_WORD_W +: `CACHE_WORD_W] : '0;
  assign cacheresp_type = req_type;

  // Line-aligned memory address with the old tag when evicting
  assign memreq_addr = {evict_sel ? tag_rdata : req_tag, req_idx, {`CACHE_IDX_LSB{1'b0}}};
  assign memreq_data = data_rdata;

endmodule

/* logic/blocking_cache.sv */
// Direct-mapped write-back blocking cache
// Controller FSM plus datapath, one request in flight

`timescale 1ns/1ns

`include "cache_consts.svh"

module blocking_cache (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  input  cache_pkg::req_type_e     cachereq_type,
  input  logic [`CACHE_ADDR_W-1:0] cachereq_addr,
  input  cache_pkg::word_t         cachereq_data,
  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  output cache_pkg::req_type_e     cacheresp_type,
  output cache_pkg::word_t         cacheresp_data,
  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  output cache_pkg::req_type_e     memreq_type,
  output logic [`CACHE_ADDR_W-1:0] memreq_addr,
  output cache_pkg::line_t         memreq_data,
  input  logic                     memresp_val,
  output logic                     memresp_rdy,
  input  cache_pkg::line_t         memresp_data
);

  import cache_pkg::*;

  // Controller to datapath strobes
  logic req_en;
  logic tag_wen;
  logic data_wen;
  logic line_sel;
  logic memresp_en;
  logic evict_sel;

  // Datapath status back to the controller
  req_type_e               req_type;
  logic [`CACHE_IDX_W-1:0] req_idx;
  logic                    tag_match;

  cache_ctrl ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_type      (req_type),
    .req_idx       (req_idx),
    .tag_match     (tag_match),
    .req_en        (req_en),
    .tag_wen       (tag_wen),
    .data_wen      (data_wen),
    .line_sel      (line_sel),
    .memresp_en    (memresp_en),
    .evict_sel     (evict_sel),
    .memreq_type   (memreq_type)
  );

  cache_dpath dpath (
    .clk            (clk),
    .req_en         (req_en),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .tag_wen        (tag_wen),
    .data_wen       (data_wen),
    .line_sel       (line_sel),
    .memresp_en     (memresp_en),
    .evict_sel      (evict_sel),
    .memresp_data   (memresp_data),
    .req_type       (req_type),
    .req_idx        (req_idx),
    .tag_match      (tag_match),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data)
  );

endmodule

/* verification/cache_checker.sv */
// Blocking cache protocol checker
// Handshake stability and reset behavior on the top-level ports

`timescale 1ns/1ns

`include "cache_consts.svh"

module cache_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     cachereq_rdy,
  input logic                     cacheresp_val,
  input logic                     cacheresp_rdy,
  input cache_pkg::req_type_e     cacheresp_type,
  input cache_pkg::word_t         cacheresp_data,
  input logic                     memreq_val,
  input logic                     memreq_rdy,
  input cache_pkg::req_type_e     memreq_type,
  input logic [`CACHE_ADDR_W-1:0] memreq_addr,
  input cache_pkg::line_t         memreq_data
);

  import cache_pkg::*;

  // Number of failed assertions
  int unsigned failures = 0;

  // Memory request held until accepted along with the eviction line
  memreq_hold: assert property (
    @(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_type) && $stable(memreq_addr)
      && (memreq_type != REQ_WRITE || $stable(memreq_data))
  ) else begin
    failures++;
    $error("memory request dropped or changed before memreq_rdy");
  end

  // Response type and data held until accepted
  cacheresp_hold: assert property (
    @(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_type)
      && $stable(cacheresp_data)
  ) else begin
    failures++;
    $error("cache response dropped or changed before cacheresp_rdy");
  end

  req_resp_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val)
  ) else begin
    failures++;
    $error("cachereq_rdy and cacheresp_val high in the same cycle");
  end

  reset_quiet: assert property (
    @(posedge clk) reset |=> !cacheresp_val && !memreq_val
  ) else begin
    failures++;
    $error("response or memory request valid right after reset");
  end

endmodule

bind blocking_cache cache_checker protocol_check (
  .clk            (clk),
  .reset          (reset),
  .cachereq_rdy   (cachereq_rdy),
  .cacheresp_val  (cacheresp_val),
  .cacheresp_rdy  (cacheresp_rdy),
  .cacheresp_type (cacheresp_type),
  .cacheresp_data (cacheresp_data),
  .memreq_val     (memreq_val),
  .memreq_rdy     (memreq_rdy),
  .memreq_type    (memreq_type),
  .memreq_addr    (memreq_addr),
  .memreq_data    (memreq_data)
);

/* verification/cache_tb.sv */
// Blocking cache testbench
// Directed and random requests against a word-level reference model

`timescale 1ns/1ns

`include "cache_consts.svh"

module cache_tb;

  import cache_pkg::*;

  localparam int DIRECTED_OPS = 13;
  localparam int RANDOM_OPS   = 500;
  localparam int TIMEOUT_NS   = (DIRECTED_OPS + RANDOM_OPS) * 60 * 20;

  logic                     clk;
  logic                     reset;
  logic                     cachereq_val;
  logic                     cachereq_rdy;
  req_type_e                cachereq_type;
  logic [`CACHE_ADDR_W-1:0] cachereq_addr;
  word_t                    cachereq_data;
  logic                     cacheresp_val;
  logic                     cacheresp_rdy;
  req_type_e                cacheresp_type;
  word_t                    cacheresp_data;
  logic                     memreq_val;
  logic                     memreq_rdy;
  req_type_e                memreq_type;
  logic [`CACHE_ADDR_W-1:0] memreq_addr;
  line_t                    memreq_data;
  logic                     memresp_val;
  logic                     memresp_rdy;
  line_t                    memresp_data;

  // Memory lines, reference words and the log of memory requests
  line_t                    mem_lines [logic [`CACHE_ADDR_W-1:0]];
  word_t                    ref_words [logic [`CACHE_ADDR_W-1:0]];
  req_type_e                log_types [$];
  logic [`CACHE_ADDR_W-1:0] log_addrs [$];
  line_t                    log_lines [$];

  // Expected directory, keeps random inits away from dirty lines
  logic                     dir_valid [`CACHE_LINES];
  tag_t                     dir_tag   [`CACHE_LINES];
  logic                     dir_dirty [`CACHE_LINES];

  blocking_cache DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Memory and reference model
  // --------------------------------------------------------------------------

  function automatic word_t fill_word(input logic [`CACHE_ADDR_W-1:0] addr);
    return {addr[15:0] ^ 16'h5a5a, addr[31:16] ^ 16'hc3c3};
  endfunction

  function automatic line_t mem_fetch(input logic [`CACHE_ADDR_W-1:0] line_addr);
    line_t line;
    int    k;
    if (mem_lines.exists(line_addr)) begin
      line = mem_lines[line_addr];
    end else begin
      for (k = 0; k < 4; k++) begin
        line[k*`CACHE_WORD_W +: `CACHE_WORD_W] = fill_word(line_addr + k*4);
      end
    end
    return line;
  endfunction

  function automatic word_t ref_read(input logic [`CACHE_ADDR_W-1:0] addr);
    word_t value;
    if (ref_words.exists(addr)) begin
      value = ref_words[addr];
    end else begin
      value = fill_word(addr);
    end
    return value;
  endfunction

  function automatic line_t ref_line(input logic [`CACHE_ADDR_W-1:0] line_addr);
    line_t line;
    int    k;
    for (k = 0; k < 4; k++) begin
      line[k*`CACHE_WORD_W +: `CACHE_WORD_W] = ref_read(line_addr + k*4);
    end
    return line;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("*** TEST FAILED ***");
      $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic model_update(input req_type_e kind, input logic [`CACHE_ADDR_W-1:0] addr,
                              input word_t data);
    logic [`CACHE_IDX_W-1:0]  idx;
    tag_t                     tag;
    line_t                    line;
    logic [`CACHE_ADDR_W-1:0] line_addr;
    idx       = addr[`CACHE_IDX_LSB +: `CACHE_IDX_W];
    tag       = addr[`CACHE_TAG_LSB +: `CACHE_TAG_W];
    line_addr = {addr[`CACHE_ADDR_W-1:`CACHE_IDX_LSB], 4'b0000};
    if (kind != REQ_READ) begin
      ref_words[addr] = data;
    end
    // Init lines are clean, so memory takes the word as well
    if (kind == REQ_INIT) begin
      line = mem_fetch(line_addr);
      line[addr[3:2]*`CACHE_WORD_W +: `CACHE_WORD_W] = data;
      mem_lines[line_addr] = line;
    end
    if (kind == REQ_WRITE) begin
      dir_dirty[idx] = 1'b1;
    end else if (kind == REQ_INIT || !dir_valid[idx] || dir_tag[idx] != tag) begin
      dir_dirty[idx] = 1'b0;
    end
    dir_valid[idx] = 1'b1;
    dir_tag[idx]   = tag;
  endtask

  // Line memory with random ready and response delays
  initial begin : memory_model
    int                       delay;
    line_t                    line;
    logic [`CACHE_ADDR_W-1:0] addr;
    req_type_e                kind;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    forever begin
      @(negedge clk);
      if (memreq_val) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        // Payload holds while val is high, the transfer is the next edge
        kind       = memreq_type;
        addr       = memreq_addr;
        line       = memreq_data;
        memreq_rdy = 1'b1;
        @(negedge clk);
        memreq_rdy = 1'b0;
        log_types.push_back(kind);
        log_addrs.push_back(addr);
        log_lines.push_back(line);
        check_value("memory address alignment", 0, addr[3:0]);
        if (kind == REQ_WRITE) begin
          check_value($sformatf("eviction of line %h", addr), ref_line(addr), line);
          mem_lines[addr] = line;
        end else begin
          line = mem_fetch(addr);
        end
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        memresp_val  = 1'b1;
        memresp_data = line;
        while (!memresp_rdy) @(negedge clk);
        @(negedge clk);
        memresp_val = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Processor side
  // --------------------------------------------------------------------------

  // Latency counts rising edges from acceptance to the response transfer
  task automatic run_request(input req_type_e kind, input logic [`CACHE_ADDR_W-1:0] addr,
                             input word_t data, input logic stall,
                             output req_type_e rtype, output word_t rdata, output int latency);
    logic done;
    done    = 1'b0;
    latency = 0;
    @(negedge clk);
    cachereq_val  = 1'b1;
    cachereq_type = kind;
    cachereq_addr = addr;
    cachereq_data = data;
    while (!cachereq_rdy) @(negedge clk);
    @(posedge clk);
    while (!done) begin
      @(negedge clk);
      cachereq_val = 1'b0;
      if (stall) begin
        cacheresp_rdy = ($urandom_range(3, 0) != 0);
      end else begin
        cacheresp_rdy = 1'b1;
      end
      if (cacheresp_val && cacheresp_rdy) begin
        rtype = cacheresp_type;
        rdata = cacheresp_data;
        done  = 1'b1;
      end
      @(posedge clk);
      latency++;
    end
  endtask

  task automatic cache_op(input string name, input req_type_e kind,
                          input logic [`CACHE_ADDR_W-1:0] addr, input word_t data,
                          input logic stall, output int latency);
    word_t     expected;
    req_type_e rtype;
    word_t     rdata;
    expected = ref_read(addr);
    run_request(kind, addr, data, stall, rtype, rdata, latency);
    check_value($sformatf("%s type", name), kind, rtype);
    if (kind == REQ_READ) begin
      check_value($sformatf("%s data at %h", name, addr), expected, rdata);
    end
    model_update(kind, addr, data);
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $display("timeout: the cache did not finish all requests within %0d ns", TIMEOUT_NS);
    $fatal(1, "timeout");
  end

  initial begin : assertion_monitor
    wait (DUT.protocol_check.failures != 0);
    $display("*** TEST FAILED ***");
    $display("a protocol assertion on the cache ports failed");
    $fatal(1, "protocol violation");
  end

  initial begin : stimulus
    int                       seed_value;
    int                       latency;
    int                       base;
    int                       ops;
    int                       roll;
    int                       k;
    logic [`CACHE_IDX_W-1:0]  idx;
    tag_t                     tag;
    logic [1:0]               off;
    logic [`CACHE_ADDR_W-1:0] addr;
    line_t                    line;
    seed_value    = $urandom(32'h563a);
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = REQ_READ;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b0;
    for (k = 0; k < `CACHE_LINES; k++) begin
      dir_valid[k] = 1'b0;
      dir_tag[k]   = '0;
      dir_dirty[k] = 1'b0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Init one full line, then read it back as hits
    for (k = 0; k < 4; k++) begin
      cache_op("init line", REQ_INIT, 32'h0000_0120 + k*4, 32'h1111_0000 + k, 1'b0, latency);
    end
    base = log_types.size();
    for (k = 0; k < 4; k++) begin
      cache_op("init then read", REQ_READ, 32'h0000_0120 + k*4, '0, 1'b0, latency);
      check_value("init then read latency", 3, latency);
    end
    check_value("init then read memory traffic", base, log_types.size());

    // Write hit stays in the cache
    base = log_types.size();
    cache_op("write hit", REQ_WRITE, 32'h0000_0128, 32'hdead_beef, 1'b0, latency);
    cache_op("write hit readback", REQ_READ, 32'h0000_0128, '0, 1'b0, latency);
    check_value("write hit memory traffic", base, log_types.size());

    // Clean read miss
    base = log_types.size();
    cache_op("clean read miss", REQ_READ, 32'h0000_0534, '0, 1'b0, latency);
    check_value("clean read miss request count", base + 1, log_types.size());
    check_value("clean read miss request type", REQ_READ, log_types[base]);
    check_value("clean read miss address", 32'h0000_0530, log_addrs[base]);

    // Dirty line at index 4 replaced by another tag
    cache_op("dirty eviction setup", REQ_WRITE, 32'h0000_0748, 32'h1234_5678, 1'b0, latency);
    base = log_types.size();
    cache_op("dirty eviction", REQ_READ, 32'h0000_0944, '0, 1'b0, latency);
    check_value("dirty eviction request count", base + 2, log_types.size());
    check_value("dirty eviction first type", REQ_WRITE, log_types[base]);
    check_value("dirty eviction write address", 32'h0000_0740, log_addrs[base]);
    line = log_lines[base];
    check_value("dirty eviction written word", 32'h1234_5678, line[95:64]);
    check_value("dirty eviction second type", REQ_READ, log_types[base + 1]);
    check_value("dirty eviction read address", 32'h0000_0940, log_addrs[base + 1]);

    // Random mix over three tags and every index
    ops = 0;
    while (ops < RANDOM_OPS) begin
      roll = $urandom_range(9, 0);
      idx  = $urandom_range(15, 0);
      tag  = 24'h000a00 + $urandom_range(2, 0);
      off  = $urandom_range(3, 0);
      addr = {tag, idx, off, 2'b00};
      if (roll == 0 && !dir_dirty[idx] && ops + 4 <= RANDOM_OPS) begin
        // Whole line, so no stale words of an older tag remain
        for (k = 0; k < 4; k++) begin
          cache_op("random init", REQ_INIT, {tag, idx, k[1:0], 2'b00}, $urandom(), 1'b1,
                   latency);
        end
        ops = ops + 4;
      end else if (roll < 5) begin
        cache_op("random read", REQ_READ, addr, '0, 1'b1, latency);
        ops++;
      end else begin
        cache_op("random write", REQ_WRITE, addr, $urandom(), 1'b1, latency);
        ops++;
      end
    end

    if (DUT.protocol_check.failures == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $display("protocol assertions failed %0d times", DUT.protocol_check.failures);
      $fatal(1, "protocol violation");
    end
  end

endmodule

/* src.f */
+incdir+logic
logic/cache_pkg.sv
logic/cache_sram.sv
logic/cache_ctrl.sv
logic/cache_dpath.sv
logic/blocking_cache.sv
verification/cache_checker.sv
verification/cache_tb.sv

/* Bender.yml */
package:
  name: blocking_cache

export_include_dirs:
  - logic

sources:
  - logic/cache_pkg.sv
  - logic/cache_sram.sv
  - logic/cache_ctrl.sv
  - logic/cache_dpath.sv
  - logic/blocking_cache.sv
  - target: test
    files:
      - verification/cache_checker.sv
      - verification/cache_tb.sv
